//--- hw/free_list.sv
module free_list #(
    parameter int NUM_PHYS = rename_pkg::def_num_phys,
    parameter int NUM_ARCH = rename_pkg::def_num_arch,
    parameter int NUM_CKPT = rename_pkg::def_num_ckpt,
    localparam int TAG_W   = $clog2(NUM_PHYS),
    localparam int PTR_W   = TAG_W + 1,
    localparam int PAGE_W  = (NUM_CKPT > 1) ? $clog2(NUM_CKPT) : 1
) (
    input  logic                clk,
    input  logic                arst_n,
    input  rename_pkg::ctl_op_e op,
    input  logic [PAGE_W-1:0]   op_page,
    input  logic                alloc_en,
    input  logic                rel_en,
    input  logic [TAG_W-1:0]    rel_tag,
    output logic                alloc_valid,
    output logic [TAG_W-1:0]    alloc_tag,
    output logic [PTR_W-1:0]    free_count,
    output logic [NUM_CKPT-1:0] ckpt_valid,
    output logic                restore_fail
);
    import rename_pkg::*;

    localparam int FREE_MAX = NUM_PHYS - NUM_ARCH;

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    logic [TAG_W-1:0] tag_buf [NUM_PHYS];
    logic [PTR_W-1:0] ckpt_head [NUM_CKPT]; // head pointer per page.

    logic [PTR_W-1:0] head; // next tag to hand out.
    logic [PTR_W-1:0] tail; // next slot for a released tag.
    logic             init_q;
    logic             empty;
    logic             full;
    logic             pop;
    logic             restore_ok;
    logic             restore_bad;

    assign free_count  = tail - head; // the wrap bit keeps this exact.
    assign empty       = (head == tail);
    assign full        = (free_count == PTR_W'(FREE_MAX));
    assign pop         = alloc_en & ~empty;
    assign restore_ok  = (op == ctl_restore) && ckpt_valid[op_page];
    assign restore_bad = (op == ctl_restore) && !ckpt_valid[op_page];

    // ------------------------------------------------------------
    // pointers and checkpoint state
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head         <= '0;
            tail         <= PTR_W'(FREE_MAX);
            alloc_valid  <= 1'b0;
            ckpt_valid   <= '0;
            restore_fail <= 1'b0;
        end else if (op == ctl_flush) begin
            head         <= '0;
            tail         <= PTR_W'(FREE_MAX);
            alloc_valid  <= 1'b0;
            ckpt_valid   <= '0;
            restore_fail <= 1'b0;
        end else begin
            alloc_valid <= pop;
            tail        <= tail + PTR_W'(rel_en);
            if (restore_ok) begin
                // tags taken since the save become free again.
                head                <= ckpt_head[op_page];
                ckpt_valid[op_page] <= 1'b0;
            end else begin
                head <= head + PTR_W'(pop);
            end
            if (op == ctl_save) begin
                ckpt_valid[op_page] <= 1'b1;
            end
            if (restore_bad) begin
                restore_fail <= 1'b1; // sticky until the next flush.
            end
        end
    end

    // high through reset so the buffer is filled before the first request.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_q <= 1'b1;
        end else begin
            init_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // tag buffer and checkpoint table
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (op == ctl_flush || init_q) begin
            for (int i = 0; i < FREE_MAX; i++) begin
                tag_buf[i] <= TAG_W'(NUM_ARCH + i);
            end
        end else if (rel_en) begin
            tag_buf[tail[TAG_W-1:0]] <= rel_tag;
        end
        if (pop) begin
            alloc_tag <= tag_buf[head[TAG_W-1:0]];
        end
        if (op == ctl_save) begin
            ckpt_head[op_page] <= head; // value before a pop in this cycle.
        end
    end

    // the architectural tags are never all free at once.
    count_in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
        free_count <= PTR_W'(FREE_MAX));

    // a release into a full list means a tag was freed twice.
    no_push_when_full_a: assert property (@(posedge clk) disable iff (!arst_n)
        rel_en |-> !full);

endmodule

//--- hw/rename_apb_regs.sv
module rename_apb_regs #(
    parameter int NUM_PHYS = rename_pkg::def_num_phys,
    parameter int NUM_CKPT = rename_pkg::def_num_ckpt,
    localparam int CNT_W   = $clog2(NUM_PHYS) + 1
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic [CNT_W-1:0]    free_count,
    input  logic [NUM_CKPT-1:0] ckpt_valid,
    input  logic                restore_fail,
    output logic                sw_flush
);
    import rename_pkg::*;

    logic        access;
    logic        hit_status;
    logic        hit_ckpt;
    logic        hit_ctrl;
    logic        hit_ro;
    logic [31:0] status_word;
    logic [31:0] ckpt_word;

    assign access     = psel & penable;
    assign hit_status = (paddr == reg_status_addr);
    assign hit_ckpt   = (paddr == reg_ckpt_addr);
    assign hit_ctrl   = (paddr == reg_ctrl_addr);
    assign hit_ro     = hit_status | hit_ckpt;

    assign pready = 1'b1; // no wait states.

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------

    always_comb begin
        status_word                = '0;
        status_word[CNT_W-1:0]     = free_count;
        status_word[31]            = restore_fail;
        ckpt_word                  = '0;
        ckpt_word[NUM_CKPT-1:0]    = ckpt_valid;
    end

    // CONTROL reads back as zero.
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_status) begin
                prdata = status_word;
            end else if (hit_ckpt) begin
                prdata = ckpt_word;
            end
        end
    end

    assign pslverr = access & (~(hit_ro | hit_ctrl) | (pwrite & hit_ro));

    // ------------------------------------------------------------
    // control write
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sw_flush <= 1'b0;
        end else begin
            sw_flush <= access & pwrite & hit_ctrl & pwdata[0]; // one-cycle pulse.
        end
    end

    // an access phase must follow a setup phase of the same transfer.
    penable_needs_psel_a: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel);

endmodule

//--- hw/rename_pkg.sv
package rename_pkg;

    // ------------------------------------------------------------
    // control opcodes
    // ------------------------------------------------------------

    // one opcode per cycle travels from the request stage to the free list.
    typedef enum logic [1:0] {
        ctl_none    = 2'd0,
        ctl_flush   = 2'd1,
        ctl_save    = 2'd2,
        ctl_restore = 2'd3
    } ctl_op_e;

    // ------------------------------------------------------------
    // APB register map
    // ------------------------------------------------------------

    localparam logic [11:0] reg_status_addr = 12'h000; // free count and restore_fail.
    localparam logic [11:0] reg_ckpt_addr   = 12'h004; // checkpoint valid bitmap.
    localparam logic [11:0] reg_ctrl_addr   = 12'h008; // bit 0 requests a flush.

    // ------------------------------------------------------------
    // default sizes
    // ------------------------------------------------------------

    // tags below def_num_arch hold the architectural state after a flush.
    localparam int def_num_phys = 128;
    localparam int def_num_arch = 32;
    localparam int def_num_ckpt = 4;

endpackage

//--- hw/rename_req_stage.sv
module rename_req_stage #(
    parameter int NUM_CKPT = rename_pkg::def_num_ckpt,
    parameter int NUM_PHYS = rename_pkg::def_num_phys,
    localparam int TAG_W   = $clog2(NUM_PHYS),
    localparam int PAGE_W  = (NUM_CKPT > 1) ? $clog2(NUM_CKPT) : 1
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                alloc_req,
    input  logic                release_valid,
    input  logic [TAG_W-1:0]    release_tag,
    input  logic                save_state,
    input  logic                restore_state,
    input  logic [PAGE_W-1:0]   ckpt_page,
    input  logic                exception,
    input  logic                mret,
    input  logic                sw_flush,
    output rename_pkg::ctl_op_e op,
    output logic [PAGE_W-1:0]   op_page,
    output logic                alloc_en,
    output logic                rel_en,
    output logic [TAG_W-1:0]    rel_tag
);
    import rename_pkg::*;

    logic    flush;
    ctl_op_e op_next;
    logic    alloc_next;
    logic    rel_next;

    assign flush = exception | mret | sw_flush;

    // flush wins over restore, restore wins over save.
    always_comb begin
        if (flush) begin
            op_next = ctl_flush;
        end else if (restore_state) begin
            op_next = ctl_restore;
        end else if (save_state) begin
            op_next = ctl_save;
        end else begin
            op_next = ctl_none;
        end
    end

    // a flush refills the list, so nothing else may touch it in that cycle.
    assign alloc_next = alloc_req & ~flush & ~restore_state;
    assign rel_next   = release_valid & ~flush; // releases survive a restore.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op       <= ctl_none;
            alloc_en <= 1'b0;
            rel_en   <= 1'b0;
        end else begin
            op       <= op_next;
            alloc_en <= alloc_next;
            rel_en   <= rel_next;
        end
    end

    always_ff @(posedge clk) begin
        op_page <= ckpt_page;
        rel_tag <= release_tag;
    end

    // the rename stage never asks to save and restore in the same cycle.
    save_restore_excl_a: assert property (@(posedge clk) disable iff (!arst_n)
        !(save_state && restore_state));

endmodule

//--- hw/rename_unit.sv
module rename_unit #(
    parameter int NUM_PHYS = rename_pkg::def_num_phys,
    parameter int NUM_ARCH = rename_pkg::def_num_arch,
    parameter int NUM_CKPT = rename_pkg::def_num_ckpt,
    localparam int TAG_W   = $clog2(NUM_PHYS),
    localparam int PAGE_W  = (NUM_CKPT > 1) ? $clog2(NUM_CKPT) : 1,
    localparam int CNT_W   = TAG_W + 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alloc_req,
    output logic              alloc_valid,
    output logic [TAG_W-1:0]  alloc_tag,
    input  logic              release_valid,
    input  logic [TAG_W-1:0]  release_tag,
    input  logic              save_state,
    input  logic              restore_state,
    input  logic [PAGE_W-1:0] ckpt_page,
    input  logic              exception,
    input  logic              mret,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [11:0]       paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr
);
    import rename_pkg::*;

    ctl_op_e             op;
    logic [PAGE_W-1:0]   op_page;
    logic                alloc_en;
    logic                rel_en;
    logic [TAG_W-1:0]    rel_tag;
    logic [CNT_W-1:0]    free_count;
    logic [NUM_CKPT-1:0] ckpt_valid;
    logic                restore_fail;
    logic                sw_flush;

    rename_req_stage #(.NUM_CKPT(NUM_CKPT), .NUM_PHYS(NUM_PHYS)) req_stage_i (
        .clk, .arst_n, .alloc_req, .release_valid, .release_tag, .save_state,
        .restore_state, .ckpt_page, .exception, .mret, .sw_flush,
        .op, .op_page, .alloc_en, .rel_en, .rel_tag
    );

    free_list #(.NUM_PHYS(NUM_PHYS), .NUM_ARCH(NUM_ARCH), .NUM_CKPT(NUM_CKPT)) free_list_i (
        .clk, .arst_n, .op, .op_page, .alloc_en, .rel_en, .rel_tag,
        .alloc_valid, .alloc_tag, .free_count, .ckpt_valid, .restore_fail
    );

    rename_apb_regs #(.NUM_PHYS(NUM_PHYS), .NUM_CKPT(NUM_CKPT)) apb_regs_i (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .pslverr, .free_count, .ckpt_valid, .restore_fail, .sw_flush
    );

endmodule

//--- rename_unit.f
hw/rename_pkg.sv
hw/rename_req_stage.sv
hw/free_list.sv
hw/rename_apb_regs.sv
hw/rename_unit.sv
tests/rename_unit_tb.sv

//--- tests/rename_unit_tb.sv
module rename_unit_tb;
    import rename_pkg::*;

    localparam int tag_w      = $clog2(def_num_phys);
    localparam int max_cycles = 512;
    localparam int apb_none   = 0;
    localparam int apb_read   = 1;
    localparam int apb_write  = 2;
    localparam int c_alloc = 1, c_rel = 2, c_save = 4, c_restore = 8, c_exc = 16, c_mret = 32;

    logic             clk, arst_n, alloc_req, alloc_valid, release_valid;
    logic             save_state, restore_state, exception, mret;
    logic [tag_w-1:0] alloc_tag, release_tag;
    logic [1:0]       ckpt_page;
    logic             psel, penable, pwrite, pready, pslverr;
    logic [11:0]      paddr;
    logic [31:0]      pwdata, prdata;

    int          row_test [$], row_count [$], row_flags [$], row_page [$], row_apb [$];
    logic [11:0] row_addr [$];
    logic [31:0] row_wdata [$];

    int     cyc_row [max_cycles];   // table row behind each cycle.
    bit     exp_valid [max_cycles];
    int     exp_tag [max_cycles];
    bit     flush_at [max_cycles];  // a CONTROL write reaches the request stage here.
    int     test_err [8];
    int     ncyc, checks, errors, cycle_cnt, cycle_limit;
    integer seed = 18979;

    // reference model of free tags in hand-out order and allocated tags in allocation order.
    int                    free_q [$];
    int                    in_use [$];
    int                    taken_cnt [def_num_ckpt]; // pops since the page was saved.
    bit [def_num_ckpt-1:0] ckpt_vld;
    bit                    rfail;
    bit                    apb_pending, apb_access, exp_read, exp_err;
    logic [31:0]           exp_rdata;
    int                    apb_test;

    rename_unit rename_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: simulation did not finish");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic add_row(input int test, input int count, input int flags, input int page,
                           input int apb, input logic [11:0] addr, input logic [31:0] wdata);
        row_test.push_back(test);
        row_count.push_back(count);
        row_flags.push_back(flags);
        row_page.push_back(page);
        row_apb.push_back(apb);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    task automatic model_flush();
        free_q.delete();
        in_use.delete();
        for (int t = def_num_arch; t < def_num_phys; t++) begin
            free_q.push_back(t);
        end
        ckpt_vld = '0;
        rfail    = 1'b0;
    endtask

    // tags taken since a live save are kept out because a restore hands them out again.
    function automatic int pick_release();
        int guard;
        int idx;
        int tag;
        guard = 0;
        for (int p = 0; p < def_num_ckpt; p++) begin
            if (ckpt_vld[p] && taken_cnt[p] > guard) begin
                guard = taken_cnt[p];
            end
        end
        if (in_use.size() <= guard) begin
            $display("table row releases a tag but no allocated tag can be freed at %0t", $time);
            errors++;
            return -1;
        end
        idx = $unsigned($random(seed)) % (in_use.size() - guard);
        tag = in_use[idx];
        in_use.delete(idx);
        return tag;
    endfunction

    task automatic apb_setup(input int r, input int n);
        logic [11:0] a;
        a         = row_addr[r];
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = (row_apb[r] == apb_write);
        paddr     = a;
        pwdata    = row_wdata[r];
        exp_read  = !pwrite;
        exp_err   = !(a == reg_status_addr || a == reg_ckpt_addr || a == reg_ctrl_addr)
                    || (pwrite && a != reg_ctrl_addr);
        exp_rdata = '0;
        if (a == reg_status_addr) begin
            exp_rdata[31]  = rfail;
            exp_rdata[7:0] = 8'(free_q.size());
        end else if (a == reg_ckpt_addr) begin
            exp_rdata[def_num_ckpt-1:0] = ckpt_vld;
        end
        if (pwrite && a == reg_ctrl_addr && pwdata[0]) begin
            flush_at[n + 2] = 1'b1;
        end
        apb_test    = row_test[r];
        apb_pending = 1'b1;
    endtask

    task automatic apply_cycle(input int n);
        int r;
        int flags;
        int page;
        int tag;
        int back;
        bit flush;
        r     = (n < ncyc) ? cyc_row[n] : -1;
        flags = (r >= 0) ? row_flags[r] : 0;
        page  = (r >= 0) ? row_page[r] : 0;
        flush = (flags & (c_exc | c_mret)) != 0 || flush_at[n];
        tag   = -1;
        exp_valid[n] = 1'b0;
        apb_access   = apb_pending;
        if (apb_pending) begin
            penable     = 1'b1;
            apb_pending = 1'b0;
        end else if (r >= 0 && (n == 0 || cyc_row[n-1] != r) && row_apb[r] != apb_none) begin
            apb_setup(r, n);
        end else begin
            psel    = 1'b0;
            penable = 1'b0;
        end
        if ((flags & c_rel) != 0 && !flush) begin
            tag = pick_release();
        end
        alloc_req     = (flags & c_alloc) != 0;
        release_valid = (tag >= 0);
        release_tag   = (tag >= 0) ? tag_w'(tag) : '0;
        save_state    = (flags & c_save) != 0;
        restore_state = (flags & c_restore) != 0;
        ckpt_page     = page[1:0];
        exception     = (flags & c_exc) != 0;
        mret          = (flags & c_mret) != 0;
        if (flush) begin
            model_flush();
        end else begin
            if (restore_state && ckpt_vld[page]) begin
                back = taken_cnt[page];
                repeat (back) free_q.push_front(in_use.pop_back());
                for (int p = 0; p < def_num_ckpt; p++) begin
                    taken_cnt[p] = (taken_cnt[p] > back) ? taken_cnt[p] - back : 0;
                end
                ckpt_vld[page] = 1'b0;
            end else if (restore_state) begin
                rfail = 1'b1;
            end else begin
                if (save_state) begin
                    ckpt_vld[page]  = 1'b1;
                    taken_cnt[page] = 0;
                end
                if (alloc_req && free_q.size() > 0) begin
                    exp_valid[n] = 1'b1;
                    exp_tag[n]   = free_q.pop_front();
                    in_use.push_back(exp_tag[n]);
                    for (int p = 0; p < def_num_ckpt; p++) begin
                        taken_cnt[p] += ckpt_vld[p];
                    end
                end
            end
            if (tag >= 0) begin
                free_q.push_back(tag); // released tags go behind every free tag.
            end
        end
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    task automatic check_alloc(input int j);
        bit ok;
        int test;
        test = row_test[cyc_row[j]];
        ok   = (alloc_valid === exp_valid[j])
               && (!exp_valid[j] || alloc_tag === tag_w'(exp_tag[j]));
        checks++;
        assert (ok) else begin
            errors++;
            test_err[test]++;
            $display("mismatch at %0t: cycle %0d expected valid %0b tag %0d, got valid %0b tag %0d",
                     $time, j, exp_valid[j], exp_tag[j], alloc_valid, alloc_tag);
        end
        if (j == ncyc - 1 || row_test[cyc_row[j+1]] != test) begin
            $display("test %0d done with %0d errors", test, test_err[test]);
        end
    endtask

    task automatic check_apb();
        checks++;
        assert (pready === 1'b1 && pslverr === exp_err && (!exp_read || prdata === exp_rdata))
        else begin
            errors++;
            test_err[apb_test]++;
            $display("mismatch at %0t: APB 0x%03h expected data %08h err %0b, got %08h err %0b",
                     $time, paddr, exp_rdata, exp_err, prdata, pslverr);
        end
    endtask

    initial begin
        {arst_n, alloc_req, release_valid, release_tag, save_state, restore_state} = '0;
        {ckpt_page, exception, mret, psel, penable, pwrite, paddr, pwdata} = '0;
        add_row(1, 1, 0, 0, apb_read, reg_status_addr, 0);
        add_row(1, 5, c_alloc, 0, apb_none, 0, 0);
        add_row(1, 2, 0, 0, apb_none, 0, 0);
        add_row(1, 1, 0, 0, apb_read, reg_status_addr, 0);
        add_row(1, 1, 0, 0, apb_none, 0, 0);
        add_row(2, 1, c_rel, 0, apb_none, 0, 0);
        add_row(2, 93, c_alloc, 0, apb_none, 0, 0); // the last request finds the list empty.
        add_row(2, 1, 0, 0, apb_read, reg_status_addr, 0);
        add_row(2, 1, 0, 0, apb_none, 0, 0);
        add_row(2, 3, c_rel, 0, apb_none, 0, 0);
        add_row(2, 3, c_alloc, 0, apb_none, 0, 0);
        add_row(3, 6, c_rel, 0, apb_none, 0, 0);
        add_row(3, 1, c_save, 1, apb_none, 0, 0);
        add_row(3, 3, c_alloc, 0, apb_none, 0, 0);
        add_row(3, 2, c_rel, 0, apb_none, 0, 0);
        add_row(3, 1, 0, 0, apb_read, reg_ckpt_addr, 0);
        add_row(3, 1, c_alloc | c_restore, 1, apb_none, 0, 0);
        add_row(3, 1, 0, 0, apb_none, 0, 0);
        add_row(3, 1, 0, 0, apb_read, reg_ckpt_addr, 0);
        add_row(3, 8, c_alloc, 0, apb_none, 0, 0);
        add_row(4, 1, c_exc, 0, apb_none, 0, 0);
        add_row(4, 1, c_alloc, 0, apb_none, 0, 0);
        add_row(4, 1, 0, 0, apb_read, reg_status_addr, 0);
        add_row(4, 1, c_save, 2, apb_none, 0, 0);
        add_row(4, 1, c_mret, 0, apb_none, 0, 0);
        add_row(4, 1, 0, 0, apb_read, reg_ckpt_addr, 0);
        add_row(4, 1, c_alloc, 0, apb_none, 0, 0);
        add_row(4, 1, c_alloc | c_save, 0, apb_none, 0, 0);
        add_row(4, 1, 0, 0, apb_write, reg_ctrl_addr, 1);
        add_row(4, 2, 0, 0, apb_none, 0, 0);
        add_row(4, 1, 0, 0, apb_read, reg_status_addr, 0);
        add_row(4, 1, 0, 0, apb_none, 0, 0);
        add_row(4, 1, 0, 0, apb_read, reg_ckpt_addr, 0);
        add_row(4, 1, c_alloc, 0, apb_none, 0, 0);
        add_row(5, 1, c_restore, 3, apb_none, 0, 0);
        add_row(5, 2, c_alloc, 0, apb_none, 0, 0);
        add_row(5, 1, 0, 0, apb_read, reg_status_addr, 0);
        add_row(5, 1, 0, 0, apb_none, 0, 0);
        add_row(5, 1, 0, 0, apb_read, 12'h00c, 0);
        add_row(5, 1, 0, 0, apb_none, 0, 0);
        add_row(5, 1, 0, 0, apb_write, reg_status_addr, 0);
        add_row(5, 2, 0, 0, apb_none, 0, 0);
        for (int r = 0; r < row_test.size(); r++) begin
            repeat (row_count[r]) begin
                cyc_row[ncyc] = r;
                ncyc++;
            end
        end
        cycle_limit = ncyc + 8 + 20;
        model_flush();
        repeat (8) @(posedge clk);
        #10;
        arst_n = 1'b1;
        for (int n = 0; n < ncyc + 2; n++) begin
            @(posedge clk);
            #10;
            if (n >= 2) begin
                check_alloc(n - 2); // results show two edges after the drive.
            end
            apply_cycle(n);
            if (apb_access) begin
                #40;
                check_apb();
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
